//--- hdl/e2p_map_pkg.sv
// ------------------
// EEPROM map definitions
// Word types, per-channel word layout and the calibration factor
// record shared by the reader and the factor table
// ------------------
`default_nettype none

package e2p_map_pkg;

    // ------------------
    // EEPROM bus types
    // ------------------
    typedef logic [15:0] e2p_addr_t;
    typedef logic [31:0] e2p_word_t;

    // ------------------
    // Channel layout
    // ------------------
    // Each channel holds four words in the order header, k, b, CRC
    localparam e2p_addr_t WORD_STRIDE = 16'd4;
    localparam e2p_addr_t CH_STRIDE   = 16'd16;

    // Channel number lives in the low bits of the header word
    localparam int CH_ID_BITS = 5;

    localparam int MAX_CH = 16;
    typedef logic [$clog2(MAX_CH)-1:0] ch_idx_t;

    // ------------------
    // Factor records
    // ------------------
    // k defaults to 1.0 in single precision float
    localparam e2p_word_t K_DEFAULT = 32'h3F80_0000;
    localparam e2p_word_t B_DEFAULT = 32'h0000_0000;

    typedef struct packed {
        e2p_word_t k;
        e2p_word_t b;
    } cal_factor_t;

endpackage

`default_nettype wire

//--- hdl/cal_seq_pkg.sv
// ------------------
// Read sequencer definitions
// FSM states, word kinds, CRC types and the per-channel
// result record passed to the factor table
// ------------------
`default_nettype none

package cal_seq_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_FEED,
        ST_CHECK,
        ST_NEXT,
        ST_DONE
    } seq_state_t;

    // Encoding doubles as the word offset inside a channel
    typedef enum logic [1:0] {
        W_HDR = 2'd0,
        W_K   = 2'd1,
        W_B   = 2'd2,
        W_CRC = 2'd3
    } word_sel_t;

    typedef logic [15:0] crc16_t;
    typedef logic [7:0]  crc_byte_t;

    // One record per channel with a single-cycle commit strobe
    typedef struct packed {
        logic                     commit;
        e2p_map_pkg::ch_idx_t     ch;
        e2p_map_pkg::cal_factor_t factor;
        logic                     crc_ok;
        logic                     id_ok;
    } ch_result_t;

endpackage

`default_nettype wire

//--- hdl/power_up_delay.sv
// ------------------
// Power-up delay
// Counts prescaled ticks once the EEPROM controller has finished
// its configuration and flags when the settle time has run out
// ------------------
`timescale 1ns/100ps
`default_nettype none

module power_up_delay #(
    parameter int TICK_CYCLES   = 100,
    parameter int PWR_DLY_TICKS = 65000
) (
    input  logic clk_sys,
    input  logic rst_sys_n,
    input  logic e2p_con_done,
    output logic pwr_ready
);

    localparam int PRE_W  = $clog2(TICK_CYCLES + 1);
    localparam int TICK_W = $clog2(PWR_DLY_TICKS + 1);

    typedef logic [PRE_W-1:0]  pre_cnt_t;
    typedef logic [TICK_W-1:0] tick_cnt_t;

    pre_cnt_t  pre_cnt;
    tick_cnt_t tick_cnt;
    logic      pre_wrap;

    assign pre_wrap  = e2p_con_done && (pre_cnt == pre_cnt_t'(TICK_CYCLES - 1));
    assign pwr_ready = (tick_cnt == tick_cnt_t'(PWR_DLY_TICKS));

    // Prescaler restarts whenever configuration drops
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            pre_cnt  <= '0;
            tick_cnt <= '0;
        end else begin
            if (!e2p_con_done || pre_wrap) begin
                pre_cnt <= '0;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
            // Saturates at the delay so ready stays up
            if (pre_wrap && !pwr_ready) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    a_ready_sticky : assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n)
        $past(pwr_ready) |-> pwr_ready
    ) else $error("pwr_ready fell outside reset");

endmodule

`default_nettype wire

//--- hdl/fcs16_calc.sv
// ------------------
// FCS-16 engine
// Byte-serial RFC 1662 checksum, LSB first, with a
// synchronous preset and a complemented result
// ------------------
`timescale 1ns/100ps
`default_nettype none

module fcs16_calc (
    input  logic                  clk_sys,
    input  logic                  rst_sys_n,
    input  logic                  crc_clr,
    input  cal_seq_pkg::crc_byte_t crc_din,
    input  logic                  crc_din_vld,
    output cal_seq_pkg::crc16_t   crc_dout
);

    import cal_seq_pkg::*;

    localparam crc16_t FCS_INIT = 16'hFFFF;
    localparam crc16_t FCS_POLY = 16'h8408;

    crc16_t fcs_q;

    // Eight reflected shift steps with data bit 0 first
    function automatic crc16_t fcs_byte(input crc16_t fcs, input crc_byte_t din);
        crc16_t c;
        int     i;
        c = fcs;
        for (i = 0; i < 8; i++) begin
            if (c[0] ^ din[i]) begin
                c = (c >> 1) ^ FCS_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            fcs_q <= FCS_INIT;
        end else if (crc_clr) begin
            fcs_q <= FCS_INIT;
        end else if (crc_din_vld) begin
            fcs_q <= fcs_byte(fcs_q, crc_din);
        end
    end

    assign crc_dout = ~fcs_q;

    a_clr_vs_data : assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n)
        !(crc_clr && crc_din_vld)
    ) else $error("FCS clear collides with a data byte");

endmodule

`default_nettype wire

//--- hdl/cal_read_fsm.sv
// ------------------
// Calibration read sequencer
// Requests header, k, b and CRC words for every channel,
// streams the first three through the FCS engine and checks
// the header ID and the CRC before committing the channel
// ------------------
`timescale 1ns/100ps
`default_nettype none

module cal_read_fsm #(
    parameter int                     NUM_CH        = 12,
    parameter e2p_map_pkg::e2p_addr_t CAL_BASE_ADDR = 16'h0100
) (
    input  logic                    clk_sys,
    input  logic                    rst_sys_n,
    input  logic                    pwr_ready,
    input  logic                    e2p_rd_dval,
    input  e2p_map_pkg::e2p_word_t  e2p_rd_value,
    output logic                    e2p_paramrd_en,
    output e2p_map_pkg::e2p_addr_t  e2p_reg_addr,
    output logic                    crc_clr,
    output cal_seq_pkg::crc_byte_t  crc_din,
    output logic                    crc_din_vld,
    input  cal_seq_pkg::crc16_t     crc_dout,
    output cal_seq_pkg::ch_result_t ch_result,
    output logic                    param_rd_en,
    output logic                    param_rd_done
);

    import e2p_map_pkg::*;
    import cal_seq_pkg::*;

    seq_state_t            state_q;
    seq_state_t            state_d;
    word_sel_t             word_sel;
    word_sel_t             word_nxt;
    ch_idx_t               ch_cnt;
    logic [1:0]            byte_cnt;
    logic                  last_ch;
    e2p_word_t             word_buf;
    logic [CH_ID_BITS-1:0] hdr_id;
    cal_factor_t           factor;
    crc16_t                crc_rx;
    logic                  crc_ok;
    logic                  id_ok;

    function automatic e2p_addr_t word_addr(input ch_idx_t ch, input word_sel_t w);
        return CAL_BASE_ADDR + CH_STRIDE * e2p_addr_t'(ch) + WORD_STRIDE * e2p_addr_t'(w);
    endfunction

    assign last_ch  = (ch_cnt == ch_idx_t'(NUM_CH - 1));
    assign word_nxt = word_sel_t'(word_sel + 2'd1);

    // ------------------
    // Next state
    // ------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (pwr_ready) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ:   state_d = ST_WAIT;
            ST_WAIT: begin
                // CRC word skips the byte feed
                if (e2p_rd_dval) begin
                    state_d = (word_sel == W_CRC) ? ST_CHECK : ST_FEED;
                end
            end
            ST_FEED: begin
                if (byte_cnt == 2'd3) begin
                    state_d = ST_REQ;
                end
            end
            ST_CHECK: state_d = ST_NEXT;
            ST_NEXT:  state_d = last_ch ? ST_DONE : ST_REQ;
            ST_DONE:  state_d = ST_DONE;
            default:  state_d = ST_IDLE;
        endcase
    end

    // ------------------
    // Counters and address
    // ------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state_q      <= ST_IDLE;
            ch_cnt       <= '0;
            word_sel     <= W_HDR;
            byte_cnt     <= '0;
            e2p_reg_addr <= '0;
            crc_ok       <= 1'b0;
            id_ok        <= 1'b0;
        end else begin
            state_q  <= state_d;
            byte_cnt <= (state_q == ST_FEED) ? byte_cnt + 2'd1 : 2'd0;
            case (state_q)
                ST_IDLE: begin
                    if (pwr_ready) begin
                        e2p_reg_addr <= word_addr(ch_cnt, W_HDR);
                    end
                end
                ST_FEED: begin
                    if (byte_cnt == 2'd3) begin
                        word_sel     <= word_nxt;
                        e2p_reg_addr <= word_addr(ch_cnt, word_nxt);
                    end
                end
                ST_CHECK: begin
                    id_ok  <= (hdr_id == CH_ID_BITS'(ch_cnt));
                    crc_ok <= (crc_dout == crc_rx);
                end
                ST_NEXT: begin
                    if (!last_ch) begin
                        ch_cnt       <= ch_cnt + 1'b1;
                        word_sel     <= W_HDR;
                        e2p_reg_addr <= word_addr(ch_cnt + 1'b1, W_HDR);
                    end
                end
                default: ;
            endcase
        end
    end

    // Word capture on each returned read
    always_ff @(posedge clk_sys) begin
        if (state_q == ST_WAIT && e2p_rd_dval) begin
            word_buf <= e2p_rd_value;
            case (word_sel)
                W_HDR:   hdr_id   <= e2p_rd_value[CH_ID_BITS-1:0];
                W_K:     factor.k <= e2p_rd_value;
                W_B:     factor.b <= e2p_rd_value;
                default: crc_rx   <= e2p_rd_value[15:0];
            endcase
        end
    end

    // ------------------
    // Outputs
    // ------------------
    assign e2p_paramrd_en = (state_q == ST_REQ);
    assign crc_clr        = (state_q == ST_REQ) && (word_sel == W_HDR);
    assign crc_din_vld    = (state_q == ST_FEED);
    // Least significant byte goes first
    assign crc_din        = word_buf[8*byte_cnt +: 8];
    assign param_rd_en    = (state_q != ST_IDLE) && (state_q != ST_DONE);
    assign param_rd_done  = (state_q == ST_DONE);

    always_comb begin
        ch_result.commit = (state_q == ST_NEXT);
        ch_result.ch     = ch_cnt;
        ch_result.factor = factor;
        ch_result.crc_ok = crc_ok;
        ch_result.id_ok  = id_ok;
    end

    a_single_req : assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n)
        (state_q == ST_WAIT) && !e2p_rd_dval |=> !e2p_paramrd_en && $stable(e2p_reg_addr)
    ) else $error("New EEPROM request while a read is pending");

endmodule

`default_nettype wire

//--- hdl/cal_factor_bank.sv
// ------------------
// Calibration factor bank
// Holds k and b for every channel with float 1.0 and 0 as
// reset values and keeps the CRC and header ID error flags
// ------------------
`timescale 1ns/100ps
`default_nettype none

module cal_factor_bank #(
    parameter int NUM_CH = 12
) (
    input  logic                                  clk_sys,
    input  logic                                  rst_sys_n,
    input  cal_seq_pkg::ch_result_t               ch_result,
    output e2p_map_pkg::cal_factor_t [NUM_CH-1:0] cal_factors,
    output logic [NUM_CH-1:0]                     param_crc_err,
    output logic [NUM_CH-1:0]                     param_id_err
);

    import e2p_map_pkg::*;

    localparam cal_factor_t FACTOR_DEFAULT = '{k: K_DEFAULT, b: B_DEFAULT};

    logic commit_good;

    // A channel only takes new factors when both checks pass
    assign commit_good = ch_result.commit && ch_result.crc_ok && ch_result.id_ok;

    // ------------------
    // Error flags
    // ------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            param_crc_err <= '0;
            param_id_err  <= '0;
        end else if (ch_result.commit) begin
            param_crc_err[ch_result.ch] <= !ch_result.crc_ok;
            param_id_err[ch_result.ch]  <= !ch_result.id_ok;
        end
    end

    // ------------------
    // Factor table
    // ------------------
    // Failed channels keep whatever they held before
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            cal_factors <= {NUM_CH{FACTOR_DEFAULT}};
        end else if (commit_good) begin
            cal_factors[ch_result.ch] <= ch_result.factor;
        end
    end

    a_commit_in_range : assert property (
        @(posedge clk_sys) disable iff (!rst_sys_n)
        ch_result.commit |-> (int'(ch_result.ch) < NUM_CH)
    ) else $error("Commit for channel %0d beyond NUM_CH", ch_result.ch);

endmodule

`default_nettype wire

//--- hdl/cal_param_reader.sv
// ------------------
// Calibration parameter reader
// Waits out the power-up delay, reads every channel's factors
// from the EEPROM and publishes the checked factor table
// ------------------
`timescale 1ns/100ps
`default_nettype none

module cal_param_reader #(
    parameter int                     NUM_CH        = 12,
    parameter e2p_map_pkg::e2p_addr_t CAL_BASE_ADDR = 16'h0100,
    parameter int                     TICK_CYCLES   = 100,
    parameter int                     PWR_DLY_TICKS = 65000
) (
    input  logic                                  clk_sys,
    input  logic                                  rst_sys_n,
    input  logic                                  e2p_con_done,
    input  logic                                  e2p_rd_dval,
    input  e2p_map_pkg::e2p_word_t                e2p_rd_value,
    output logic                                  e2p_paramrd_en,
    output e2p_map_pkg::e2p_addr_t                e2p_reg_addr,
    output logic                                  param_rd_en,
    output logic                                  param_rd_done,
    output logic [NUM_CH-1:0]                     param_crc_err,
    output logic [NUM_CH-1:0]                     param_id_err,
    output e2p_map_pkg::cal_factor_t [NUM_CH-1:0] cal_factors
);

    import cal_seq_pkg::*;

    logic       pwr_ready;
    logic       crc_clr;
    crc_byte_t  crc_din;
    logic       crc_din_vld;
    crc16_t     crc_dout;
    ch_result_t ch_result;

    power_up_delay #(
        .TICK_CYCLES   (TICK_CYCLES),
        .PWR_DLY_TICKS (PWR_DLY_TICKS)
    ) i_power_up_delay (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .e2p_con_done (e2p_con_done),
        .pwr_ready    (pwr_ready)
    );

    cal_read_fsm #(
        .NUM_CH        (NUM_CH),
        .CAL_BASE_ADDR (CAL_BASE_ADDR)
    ) i_cal_read_fsm (
        .clk_sys        (clk_sys),
        .rst_sys_n      (rst_sys_n),
        .pwr_ready      (pwr_ready),
        .e2p_rd_dval    (e2p_rd_dval),
        .e2p_rd_value   (e2p_rd_value),
        .e2p_paramrd_en (e2p_paramrd_en),
        .e2p_reg_addr   (e2p_reg_addr),
        .crc_clr        (crc_clr),
        .crc_din        (crc_din),
        .crc_din_vld    (crc_din_vld),
        .crc_dout       (crc_dout),
        .ch_result      (ch_result),
        .param_rd_en    (param_rd_en),
        .param_rd_done  (param_rd_done)
    );

    fcs16_calc i_fcs16_calc (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .crc_clr     (crc_clr),
        .crc_din     (crc_din),
        .crc_din_vld (crc_din_vld),
        .crc_dout    (crc_dout)
    );

    cal_factor_bank #(
        .NUM_CH (NUM_CH)
    ) i_cal_factor_bank (
        .clk_sys       (clk_sys),
        .rst_sys_n     (rst_sys_n),
        .ch_result     (ch_result),
        .cal_factors   (cal_factors),
        .param_crc_err (param_crc_err),
        .param_id_err  (param_id_err)
    );

endmodule

`default_nettype wire

//--- verif/tb_cal_param_reader.sv
// ------------------
// Calibration reader testbench
// EEPROM model with random latency, vector driven image,
// address, factor and flag checks with a closing summary
// ------------------
`timescale 1ns/100ps
`default_nettype none

module tb_cal_param_reader;

    import e2p_map_pkg::*;
    import cal_seq_pkg::*;

    localparam int        NUM_CH        = 12;
    localparam e2p_addr_t CAL_BASE_ADDR = 16'h0100;
    localparam int        TICK_CYCLES   = 4;
    localparam int        PWR_DLY_TICKS = 20;
    localparam int        VEC_COLS      = 6;
    localparam int        HOLD_CYCLES   = 200;
    localparam int        START_LIMIT   = 1000;
    localparam int        READ_LIMIT    = 5000;
    localparam int        QUIET_CYCLES  = 100;
    localparam e2p_word_t K_RESET       = 32'h3F80_0000;
    localparam e2p_word_t B_RESET       = 32'h0000_0000;

    typedef logic [NUM_CH-1:0] ch_flags_t;

    logic                     clk_sys = 1'b0;
    logic                     rst_sys_n;
    logic                     e2p_con_done;
    logic                     e2p_rd_dval;
    e2p_word_t                e2p_rd_value;
    logic                     e2p_paramrd_en;
    e2p_addr_t                e2p_reg_addr;
    logic                     param_rd_en;
    logic                     param_rd_done;
    ch_flags_t                param_crc_err;
    ch_flags_t                param_id_err;
    cal_factor_t [NUM_CH-1:0] cal_factors;

    e2p_word_t   vec_mem [0:VEC_COLS*NUM_CH-1];
    e2p_word_t   image [0:4*NUM_CH-1];
    cal_factor_t exp_factor [0:NUM_CH-1];
    ch_flags_t   exp_crc_err;
    ch_flags_t   exp_id_err;
    int          err_cnt = 0;
    int          req_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic        aborted = 1'b0;

    cal_param_reader #(
        .NUM_CH        (NUM_CH),
        .CAL_BASE_ADDR (CAL_BASE_ADDR),
        .TICK_CYCLES   (TICK_CYCLES),
        .PWR_DLY_TICKS (PWR_DLY_TICKS)
    ) i_dut (
        .clk_sys        (clk_sys),
        .rst_sys_n      (rst_sys_n),
        .e2p_con_done   (e2p_con_done),
        .e2p_rd_dval    (e2p_rd_dval),
        .e2p_rd_value   (e2p_rd_value),
        .e2p_paramrd_en (e2p_paramrd_en),
        .e2p_reg_addr   (e2p_reg_addr),
        .param_rd_en    (param_rd_en),
        .param_rd_done  (param_rd_done),
        .param_crc_err  (param_crc_err),
        .param_id_err   (param_id_err),
        .cal_factors    (cal_factors)
    );

    always #10 clk_sys = ~clk_sys;

    // ------------------
    // Helpers
    // ------------------
    // Drive and sample point just after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    // FCS-16 over header, k and b as one LSB-first bit stream
    function automatic crc16_t ref_fcs16(input e2p_word_t hdr, input e2p_word_t k,
                                         input e2p_word_t b);
        logic [95:0] stream;
        crc16_t      fcs;
        logic        fb;
        int          n;
        stream = {b, k, hdr};
        fcs    = 16'hFFFF;
        for (n = 0; n < 96; n++) begin
            fb  = fcs[0] ^ stream[n];
            fcs = {1'b0, fcs[15:1]};
            if (fb) begin
                fcs = fcs ^ 16'h8408;
            end
        end
        return ~fcs;
    endfunction

    function automatic e2p_addr_t expected_addr(input int n);
        return CAL_BASE_ADDR + e2p_addr_t'(16 * (n / 4) + 4 * (n % 4));
    endfunction

    function automatic logic addr_in_range(input e2p_addr_t addr);
        return (addr >= CAL_BASE_ADDR) && (addr[1:0] == 2'b00) &&
               (addr < CAL_BASE_ADDR + e2p_addr_t'(16 * NUM_CH));
    endfunction

    task automatic load_vectors();
        int        ch;
        e2p_word_t word_hdr;
        e2p_word_t word_k;
        e2p_word_t word_b;
        e2p_word_t crc_flip;
        $readmemh("verif/cal_param_vectors.txt", vec_mem);
        for (ch = 0; ch < NUM_CH; ch++) begin
            word_hdr            = vec_mem[VEC_COLS*ch];
            word_k              = vec_mem[VEC_COLS*ch+1];
            word_b              = vec_mem[VEC_COLS*ch+2];
            crc_flip            = vec_mem[VEC_COLS*ch+3];
            exp_crc_err[ch]     = vec_mem[VEC_COLS*ch+4][0];
            exp_id_err[ch]      = vec_mem[VEC_COLS*ch+5][0];
            image[4*ch]         = word_hdr;
            image[4*ch+1]       = word_k;
            image[4*ch+2]       = word_b;
            image[4*ch+3]       = {16'h0000, ref_fcs16(word_hdr, word_k, word_b)} ^ crc_flip;
            // Rejected channels keep the reset factors
            exp_factor[ch].k    = (exp_crc_err[ch] || exp_id_err[ch]) ? K_RESET : word_k;
            exp_factor[ch].b    = (exp_crc_err[ch] || exp_id_err[ch]) ? B_RESET : word_b;
        end
        if ($isunknown(vec_mem[VEC_COLS*NUM_CH-1])) begin
            $display("Vector file is missing or shorter than %0d channels", NUM_CH);
            err_cnt++;
            aborted = 1'b1;
        end
    endtask

    // ------------------
    // Compare tasks
    // ------------------
    task automatic check_addr(input int req_idx, input e2p_addr_t got, input e2p_addr_t exp);
        if (got !== exp) begin
            $display("Error: e2p_reg_addr request %0d got %h expected %h", req_idx, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_factor(input int ch, input cal_factor_t got, input cal_factor_t exp);
        if (got !== exp) begin
            $display("Error: cal_factors[%0d] got k=%h b=%h expected k=%h b=%h",
                     ch, got.k, got.b, exp.k, exp.b);
            err_cnt++;
        end
    endtask

    task automatic check_flags(input string name, input ch_flags_t got, input ch_flags_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("Test %0d %s: ok", num, name);
            tests_passed++;
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", num, name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    // ------------------
    // EEPROM model
    // ------------------
    initial begin : eeprom_model
        e2p_addr_t req_addr;
        int        delay;
        e2p_rd_dval  = 1'b0;
        e2p_rd_value = '0;
        void'($urandom(32'h068d2aa2));
        forever begin
            next_cycle();
            if (rst_sys_n && e2p_paramrd_en) begin
                req_addr = e2p_reg_addr;
                check_addr(req_count, req_addr, expected_addr(req_count));
                req_count++;
                delay = 1 + int'($urandom % 8);
                repeat (delay) begin
                    next_cycle();
                    check_level("e2p_paramrd_en", e2p_paramrd_en, 1'b0);
                end
                if (addr_in_range(req_addr)) begin
                    e2p_rd_value = image[int'(req_addr - CAL_BASE_ADDR) / 4];
                end else begin
                    $display("EEPROM request at address %h lies outside the calibration area",
                             req_addr);
                    err_cnt++;
                    e2p_rd_value = 32'hDEAD_BEEF;
                end
                e2p_rd_dval = 1'b1;
                next_cycle();
                e2p_rd_dval = 1'b0;
            end
        end
    end

    // ------------------
    // Test sequence
    // ------------------
    initial begin : main_seq
        int        errs;
        int        cycles;
        int        ch;
        int        reqs_at_done;
        ch_flags_t good_mask;
        rst_sys_n    = 1'b0;
        e2p_con_done = 1'b0;
        load_vectors();
        good_mask = ~(exp_crc_err | exp_id_err);
        repeat (5) @(posedge clk_sys);
        #2;
        rst_sys_n = 1'b1;

        // Nothing may move until the controller is configured
        errs = err_cnt;
        for (cycles = 0; cycles < HOLD_CYCLES; cycles++) begin
            next_cycle();
            check_level("e2p_paramrd_en", e2p_paramrd_en, 1'b0);
            check_level("param_rd_en", param_rd_en, 1'b0);
        end
        e2p_con_done = 1'b1;
        cycles = 0;
        while (!e2p_paramrd_en && cycles < START_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!e2p_paramrd_en) begin
            $display("Timeout: no EEPROM request within %0d cycles of e2p_con_done", START_LIMIT);
            err_cnt++;
            aborted = 1'b1;
        end else begin
            check_level("param_rd_en", param_rd_en, 1'b1);
            if (cycles < TICK_CYCLES * PWR_DLY_TICKS) begin
                $display("First EEPROM request after %0d cycles, before the %0d cycle delay",
                         cycles, TICK_CYCLES * PWR_DLY_TICKS);
                err_cnt++;
            end
        end
        finish_test(1, "power-up hold", errs);

        if (!aborted) begin
            errs   = err_cnt;
            cycles = 0;
            while (!param_rd_done && cycles < READ_LIMIT) begin
                next_cycle();
                cycles++;
            end
            if (!param_rd_done) begin
                $display("Timeout: param_rd_done stayed low for %0d cycles", READ_LIMIT);
                err_cnt++;
                aborted = 1'b1;
            end else if (req_count != 4 * NUM_CH) begin
                $display("Error: e2p_paramrd_en pulse count got %h expected %h",
                         req_count, 4 * NUM_CH);
                err_cnt++;
            end
            finish_test(2, "address order", errs);
        end

        if (!aborted) begin
            errs = err_cnt;
            for (ch = 0; ch < NUM_CH; ch++) begin
                if (good_mask[ch]) begin
                    check_factor(ch, cal_factors[ch], exp_factor[ch]);
                end
            end
            check_flags("param_crc_err", param_crc_err & good_mask, '0);
            check_flags("param_id_err", param_id_err & good_mask, '0);
            finish_test(3, "good channels", errs);

            errs = err_cnt;
            check_flags("param_crc_err", param_crc_err, exp_crc_err);
            for (ch = 0; ch < NUM_CH; ch++) begin
                if (exp_crc_err[ch]) begin
                    check_factor(ch, cal_factors[ch], exp_factor[ch]);
                end
            end
            finish_test(4, "CRC-bad channels", errs);

            errs = err_cnt;
            check_flags("param_id_err", param_id_err, exp_id_err);
            for (ch = 0; ch < NUM_CH; ch++) begin
                if (exp_id_err[ch]) begin
                    check_factor(ch, cal_factors[ch], exp_factor[ch]);
                end
            end
            finish_test(5, "header mismatch", errs);

            // Done is sticky and the bus stays quiet
            errs         = err_cnt;
            reqs_at_done = req_count;
            check_level("param_rd_en", param_rd_en, 1'b0);
            for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
                next_cycle();
                check_level("param_rd_done", param_rd_done, 1'b1);
                check_level("param_rd_en", param_rd_en, 1'b0);
                check_level("e2p_paramrd_en", e2p_paramrd_en, 1'b0);
            end
            if (req_count != reqs_at_done) begin
                $display("EEPROM requests appeared after param_rd_done");
                err_cnt++;
            end
            finish_test(6, "completion", errs);
        end

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0 && !aborted) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/cal_param_vectors.txt
// Columns: header k b crc_flip exp_crc_err exp_id_err, one line per channel
// Stored CRC word is the FCS-16 of header, k and b in bits 15:0, XORed with crc_flip
CA100000 3F8CCCCD 3C23D70A 00000000 0 0
CA100001 3F7AE148 BC23D70A 00000000 0 0
CA100002 3F866666 3DCCCCCD 00000000 0 0
CA100003 3F733333 BD4CCCCD 00000001 1 0
CA100004 40000000 3E800000 FFFF0000 0 0
CA100015 3F9EB852 C0A00000 00000000 0 1
CA100006 3F6147AE 41200000 00000000 0 0
CA100007 3F828F5C BF000000 00008000 1 0
CA100018 3F7D70A4 3A83126F 0000A5A5 1 1
CA100009 3FA00000 42C80000 00000000 0 0
CA10000A 3F59999A BE99999A 00000000 0 0
CA10002B 3F800001 00000001 00000000 0 0

//--- cal_param_reader.f
hdl/e2p_map_pkg.sv
hdl/cal_seq_pkg.sv
hdl/power_up_delay.sv
hdl/fcs16_calc.sv
hdl/cal_read_fsm.sv
hdl/cal_factor_bank.sv
hdl/cal_param_reader.sv
verif/tb_cal_param_reader.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the calibration reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cal_param_reader \
    -f cal_param_reader.f \
    -o tb_cal_param_reader > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_cal_param_reader > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$SIM_LOG"; then
    exit 0
else
    echo "Pass message not found in $SIM_LOG"
    exit 1
fi
